/* hdl/mpu_pkg.sv */
//////////////////////////////
// Shared types for the data-side MPU
// Privilege levels, PMP access and matching modes,
// controller states and the response status to the core
// Imported by the RTL and by the testbench
//////////////////////////////

package mpu_pkg;

  //////////////////////////////
  // Privilege and access kinds
  //////////////////////////////

  // Encoding follows the RISC-V privilege spec
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } privlvl_e;

  // Data side only, no execute
  typedef enum logic {
    PMP_ACC_READ  = 1'b0,
    PMP_ACC_WRITE = 1'b1
  } pmp_acc_e;

  // Address matching mode, the A field of a cfg byte
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // Bit positions inside one 8-bit PMP cfg byte
  localparam int PMP_CFG_R     = 0;
  localparam int PMP_CFG_W     = 1;
  localparam int PMP_CFG_A_LSB = 3;
  localparam int PMP_CFG_L     = 7;

  //////////////////////////////
  // Response controller
  //////////////////////////////

  // Wait states hold the fault until the core has drained
  typedef enum logic [2:0] {
    MPU_IDLE        = 3'd0,
    MPU_RE_ERR_WAIT = 3'd1,
    MPU_WR_ERR_WAIT = 3'd2,
    MPU_RE_ERR_RESP = 3'd3,
    MPU_WR_ERR_RESP = 3'd4
  } mpu_state_e;

  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

endpackage

/* hdl/prot_cfg_pkg.sv */
//////////////////////////////
// Memory map of the protected data port
// Fixed PMA region table, debug module window
// and the sizes of the PMP configuration ports
//////////////////////////////

package prot_cfg_pkg;

  //////////////////////////////
  // PMP sizing
  //////////////////////////////

  localparam int PMP_NUM_REGIONS = 4;

  // One cfg byte and one 32-bit address word per entry
  localparam int PMP_CFG_W_TOTAL  = 8 * PMP_NUM_REGIONS;
  localparam int PMP_ADDR_W_TOTAL = 32 * PMP_NUM_REGIONS;

  //////////////////////////////
  // PMA region table
  //////////////////////////////

  localparam int PMA_NUM_REGIONS = 3;

  // Inclusive bounds, region 0 first
  localparam logic [31:0] PMA_START [PMA_NUM_REGIONS] = '{
    32'h0000_0000, 32'h1000_0000, 32'h2000_0000
  };
  localparam logic [31:0] PMA_END [PMA_NUM_REGIONS] = '{
    32'h0000_FFFF, 32'h1000_0FFF, 32'h2000_FFFF
  };

  // Bit i describes region i
  // Region 0 RAM, region 1 I/O, region 2 ROM
  localparam logic [PMA_NUM_REGIONS-1:0] PMA_MAIN       = 3'b101;
  localparam logic [PMA_NUM_REGIONS-1:0] PMA_READONLY   = 3'b100;
  localparam logic [PMA_NUM_REGIONS-1:0] PMA_BUFFERABLE = 3'b001;
  localparam logic [PMA_NUM_REGIONS-1:0] PMA_CACHEABLE  = 3'b101;

  // Unmatched addresses behave as plain main memory
  localparam logic PMA_DEFAULT_MAIN       = 1'b1;
  localparam logic PMA_DEFAULT_READONLY   = 1'b0;
  localparam logic PMA_DEFAULT_BUFFERABLE = 1'b0;
  localparam logic PMA_DEFAULT_CACHEABLE  = 1'b0;

  // Debug module window, open to debug accesses
  localparam logic [31:0] DM_REGION_START = 32'hF000_0000;
  localparam logic [31:0] DM_REGION_END   = 32'hF000_3FFF;

endpackage

/* hdl/pma_check.sv */
//////////////////////////////
// PMA checker
// Looks the request address up in the fixed region table
// Flags misaligned I/O and writes to read-only memory,
// and gives the bus attributes of the hit region
// Purely combinational
//////////////////////////////

module pma_check import prot_cfg_pkg::*; (
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic        misaligned_i,
  input  logic        debug_region_i,
  output logic        pma_err_o,
  output logic        bufferable_o,
  output logic        cacheable_o
);

  // Attributes of the selected region
  logic reg_main;
  logic reg_readonly;
  logic reg_bufferable;
  logic reg_cacheable;

  // One hit bit per region
  logic [PMA_NUM_REGIONS-1:0] region_hit;

  //////////////////////////////
  // Region lookup
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      region_hit[i] = (addr_i >= PMA_START[i]) && (addr_i <= PMA_END[i]);
    end
  end

  always_comb begin
    // Defaults hold when nothing matches
    reg_main       = PMA_DEFAULT_MAIN;
    reg_readonly   = PMA_DEFAULT_READONLY;
    reg_bufferable = PMA_DEFAULT_BUFFERABLE;
    reg_cacheable  = PMA_DEFAULT_CACHEABLE;
    // Walk downwards so the lowest hit wins
    for (int i = PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_hit[i]) begin
        reg_main       = PMA_MAIN[i];
        reg_readonly   = PMA_READONLY[i];
        reg_bufferable = PMA_BUFFERABLE[i];
        reg_cacheable  = PMA_CACHEABLE[i];
      end
    end
  end

  //////////////////////////////
  // Error and attributes
  //////////////////////////////

  always_comb begin
    if (debug_region_i) begin
      // Debugger always gets through, default attributes
      pma_err_o    = 1'b0;
      bufferable_o = PMA_DEFAULT_BUFFERABLE;
      cacheable_o  = PMA_DEFAULT_CACHEABLE;
    end else begin
      // Split accesses only allowed to main memory
      pma_err_o    = (misaligned_i && !reg_main) || (we_i && reg_readonly);
      bufferable_o = reg_bufferable;
      cacheable_o  = reg_cacheable;
    end
  end

endmodule

/* hdl/pmp_check.sv */
//////////////////////////////
// PMP checker for data accesses
// Matches the address against the four PMP entries
// with OFF, TOR, NA4 and NAPOT modes at 4-byte granularity
// Lowest matching entry decides, lock bit binds machine mode
// Purely combinational
//////////////////////////////

module pmp_check import mpu_pkg::*, prot_cfg_pkg::*; (
  input  logic [31:0]                 addr_i,
  input  pmp_acc_e                    acc_i,
  input  privlvl_e                    priv_lvl_i,
  input  logic                        debug_region_i,
  input  logic [PMP_CFG_W_TOTAL-1:0]  pmpcfg_i,
  input  logic [PMP_ADDR_W_TOTAL-1:0] pmpaddr_i,
  output logic                        pmp_err_o
);

  // Request address bits 33:2, upper two are zero
  logic [31:0] addr_word;

  // Per-entry results
  logic [PMP_NUM_REGIONS-1:0] entry_match;
  logic [PMP_NUM_REGIONS-1:0] entry_lock;
  logic [PMP_NUM_REGIONS-1:0] entry_perm;

  logic err;

  assign addr_word = {2'b00, addr_i[31:2]};

  // Word bits covered by a NAPOT region
  // Trailing ones of the entry word set the size
  function automatic logic [31:0] napot_mask(input logic [31:0] word);
    logic [31:0] ign;
    ign[0] = 1'b1;
    for (int j = 1; j < 32; j++) begin
      ign[j] = ign[j-1] & word[j-1];
    end
    return ~ign;
  endfunction

  //////////////////////////////
  // Entry matching
  //////////////////////////////

  for (genvar i = 0; i < PMP_NUM_REGIONS; i++) begin : g_entry
    logic [7:0]  cfg;
    pmp_mode_e   mode;
    logic [31:0] word;
    logic [31:0] base_word;
    logic        hit;

    assign cfg  = pmpcfg_i[8*i +: 8];
    assign mode = pmp_mode_e'(cfg[PMP_CFG_A_LSB +: 2]);
    assign word = pmpaddr_i[32*i +: 32];

    // TOR base is the previous entry, zero below entry 0
    if (i == 0) begin : g_base_zero
      assign base_word = '0;
    end else begin : g_base_prev
      assign base_word = pmpaddr_i[32*(i-1) +: 32];
    end

    always_comb begin
      unique case (mode)
        PMP_MODE_TOR:   hit = (addr_word >= base_word) && (addr_word < word);
        PMP_MODE_NA4:   hit = (addr_word == word);
        PMP_MODE_NAPOT: hit = ((addr_word ^ word) & napot_mask(word)) == '0;
        default:        hit = 1'b0;
      endcase
    end

    assign entry_match[i] = hit;
    assign entry_lock[i]  = cfg[PMP_CFG_L];
    // Permission bit for this access kind
    assign entry_perm[i]  = (acc_i == PMP_ACC_WRITE) ? cfg[PMP_CFG_W] : cfg[PMP_CFG_R];
  end

  //////////////////////////////
  // Priority decision
  //////////////////////////////

  always_comb begin
    // No match: machine allowed, user denied
    err = (priv_lvl_i != PRIV_LVL_M);
    // Downward walk leaves the lowest match in charge
    for (int i = PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (entry_match[i]) begin
        if ((priv_lvl_i == PRIV_LVL_M) && !entry_lock[i]) begin
          err = 1'b0;
        end else begin
          err = !entry_perm[i];
        end
      end
    end
    // Debug module window is never blocked
    if (debug_region_i) begin
      err = 1'b0;
    end
  end

  assign pmp_err_o = err;

  // Known request and config must give a known verdict
  always_comb begin
    if (!$isunknown({addr_i, acc_i, priv_lvl_i, debug_region_i, pmpcfg_i, pmpaddr_i})) begin
      a_err_known: assert (!$isunknown(pmp_err_o))
        else $error("pmp_err_o unknown for a known request");
    end
  end

endmodule

/* hdl/mpu_resp_ctrl.sv */
//////////////////////////////
// MPU response controller
// Forwards passing requests to the bus with their attributes
// and returns bus responses to the core
// Failing requests are swallowed and answered with a fault
// once the core has at most one transaction in flight
//////////////////////////////

module mpu_resp_ctrl import mpu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        pma_err_i,
  input  logic        pmp_err_i,
  input  logic        core_valid_i,
  input  logic        core_we_i,
  input  logic [31:0] core_addr_i,
  input  logic [31:0] core_wdata_i,
  input  logic        core_one_txn_pend_n_i,
  input  logic        core_mpu_err_wait_i,
  input  logic        bus_ready_i,
  input  logic        bus_rvalid_i,
  input  logic [31:0] bus_rdata_i,
  input  logic        bufferable_i,
  input  logic        cacheable_i,
  output logic        core_ready_o,
  output logic        core_rvalid_o,
  output logic [31:0] core_rdata_o,
  output mpu_status_e core_status_o,
  output logic        core_mpu_err_o,
  output logic        bus_valid_o,
  output logic [31:0] bus_addr_o,
  output logic        bus_we_o,
  output logic [31:0] bus_wdata_o,
  output logic        bus_bufferable_o,
  output logic        bus_cacheable_o
);

  mpu_state_e  state_q, state_n;
  mpu_status_e status;
  logic        mpu_err;
  logic        block_core;
  logic        block_bus;
  logic        err_resp_valid;
  logic        err_accept;

  // Either checker can veto
  assign mpu_err = pma_err_i || pmp_err_i;

  //////////////////////////////
  // Fault FSM
  //////////////////////////////

  always_comb begin
    state_n        = state_q;
    status         = MPU_OK;
    block_core     = 1'b0;
    block_bus      = 1'b0;
    err_resp_valid = 1'b0;
    err_accept     = 1'b0;
    unique case (state_q)
      MPU_IDLE: begin
        if (mpu_err && core_valid_i) begin
          // Keep it off the bus but accept it from the core
          block_bus  = 1'b1;
          err_accept = 1'b1;
          if (core_mpu_err_wait_i) begin
            if (core_we_i) begin
              state_n = core_one_txn_pend_n_i ? MPU_WR_ERR_RESP : MPU_WR_ERR_WAIT;
            end else begin
              state_n = core_one_txn_pend_n_i ? MPU_RE_ERR_RESP : MPU_RE_ERR_WAIT;
            end
          end
        end
      end
      MPU_RE_ERR_WAIT, MPU_WR_ERR_WAIT: begin
        // Hold off new traffic while earlier ones drain
        block_core = 1'b1;
        block_bus  = 1'b1;
        if (core_one_txn_pend_n_i) begin
          state_n = (state_q == MPU_RE_ERR_WAIT) ? MPU_RE_ERR_RESP : MPU_WR_ERR_RESP;
        end
      end
      MPU_RE_ERR_RESP, MPU_WR_ERR_RESP: begin
        block_core     = 1'b1;
        block_bus      = 1'b1;
        err_resp_valid = 1'b1;
        status         = (state_q == MPU_RE_ERR_RESP) ? MPU_RE_FAULT : MPU_WR_FAULT;
        // Core never stalls a response
        state_n        = MPU_IDLE;
      end
      default: state_n = MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  //////////////////////////////
  // Core and bus outputs
  //////////////////////////////

  // Request path, zero latency
  assign bus_valid_o      = core_valid_i && !block_bus;
  assign bus_addr_o       = core_addr_i;
  assign bus_we_o         = core_we_i;
  assign bus_wdata_o      = core_wdata_i;
  assign bus_bufferable_o = bufferable_i;
  assign bus_cacheable_o  = cacheable_i;

  // Bus back-pressure passes through unless a fault is consumed
  assign core_ready_o = (bus_ready_i && !block_core) || err_accept;

  // Fault responses carry zero data
  assign core_rvalid_o  = bus_rvalid_i || err_resp_valid;
  assign core_rdata_o   = err_resp_valid ? 32'h0 : bus_rdata_i;
  assign core_status_o  = status;
  assign core_mpu_err_o = mpu_err;

  // Faulting request in idle must not leak to the bus
  a_no_bus_on_err: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == MPU_IDLE && mpu_err) |-> !bus_valid_o);

  // A fault response lasts exactly one cycle
  a_resp_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q inside {MPU_RE_ERR_RESP, MPU_WR_ERR_RESP}) |=> (state_q == MPU_IDLE));

endmodule

/* hdl/data_mpu.sv */
//////////////////////////////
// Data-side memory protection unit, top level
// Sits between the load/store unit and the data bus
// PMA and PMP checks run in parallel on each request,
// the response controller merges them
//////////////////////////////

module data_mpu import mpu_pkg::*, prot_cfg_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  // Core request
  input  logic                        core_valid_i,
  output logic                        core_ready_o,
  input  logic [31:0]                 core_addr_i,
  input  logic                        core_we_i,
  input  logic [31:0]                 core_wdata_i,
  input  logic                        core_dbg_i,
  input  logic                        core_misaligned_i,
  // Core state
  input  logic                        core_one_txn_pend_n_i,
  input  logic                        core_mpu_err_wait_i,
  // Core response
  output logic                        core_rvalid_o,
  output logic [31:0]                 core_rdata_o,
  output mpu_status_e                 core_status_o,
  output logic                        core_mpu_err_o,
  // PMP configuration and privilege
  input  logic [PMP_CFG_W_TOTAL-1:0]  pmpcfg_i,
  input  logic [PMP_ADDR_W_TOTAL-1:0] pmpaddr_i,
  input  privlvl_e                    priv_lvl_i,
  // Bus request
  output logic                        bus_valid_o,
  input  logic                        bus_ready_i,
  output logic [31:0]                 bus_addr_o,
  output logic                        bus_we_o,
  output logic [31:0]                 bus_wdata_o,
  output logic                        bus_bufferable_o,
  output logic                        bus_cacheable_o,
  // Bus response
  input  logic                        bus_rvalid_i,
  input  logic [31:0]                 bus_rdata_i
);

  logic     debug_region;
  logic     pma_err;
  logic     pmp_err;
  logic     bufferable;
  logic     cacheable;
  pmp_acc_e pmp_acc;

  // Debug access to the DM window, shared by both checkers
  assign debug_region = core_dbg_i && (core_addr_i >= DM_REGION_START) &&
                        (core_addr_i <= DM_REGION_END);

  assign pmp_acc = core_we_i ? PMP_ACC_WRITE : PMP_ACC_READ;

  pma_check u_pma_check (
    .addr_i         (core_addr_i),
    .we_i           (core_we_i),
    .misaligned_i   (core_misaligned_i),
    .debug_region_i (debug_region),
    .pma_err_o      (pma_err),
    .bufferable_o   (bufferable),
    .cacheable_o    (cacheable)
  );

  pmp_check u_pmp_check (
    .addr_i         (core_addr_i),
    .acc_i          (pmp_acc),
    .priv_lvl_i     (priv_lvl_i),
    .debug_region_i (debug_region),
    .pmpcfg_i       (pmpcfg_i),
    .pmpaddr_i      (pmpaddr_i),
    .pmp_err_o      (pmp_err)
  );

  mpu_resp_ctrl u_resp_ctrl (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .pma_err_i             (pma_err),
    .pmp_err_i             (pmp_err),
    .core_valid_i          (core_valid_i),
    .core_we_i             (core_we_i),
    .core_addr_i           (core_addr_i),
    .core_wdata_i          (core_wdata_i),
    .core_one_txn_pend_n_i (core_one_txn_pend_n_i),
    .core_mpu_err_wait_i   (core_mpu_err_wait_i),
    .bus_ready_i           (bus_ready_i),
    .bus_rvalid_i          (bus_rvalid_i),
    .bus_rdata_i           (bus_rdata_i),
    .bufferable_i          (bufferable),
    .cacheable_i           (cacheable),
    .core_ready_o          (core_ready_o),
    .core_rvalid_o         (core_rvalid_o),
    .core_rdata_o          (core_rdata_o),
    .core_status_o         (core_status_o),
    .core_mpu_err_o        (core_mpu_err_o),
    .bus_valid_o           (bus_valid_o),
    .bus_addr_o            (bus_addr_o),
    .bus_we_o              (bus_we_o),
    .bus_wdata_o           (bus_wdata_o),
    .bus_bufferable_o      (bus_bufferable_o),
    .bus_cacheable_o       (bus_cacheable_o)
  );

endmodule

/* test/mpu_tests.svh */
//////////////////////////////
// Directed tests for the data-side MPU
// Included into the testbench module, uses its signals,
// bus log and error counters
//////////////////////////////

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
  $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
  err_cnt++;
endtask

task automatic report_issue(input string what);
  $display("[ERROR] %0t ns: %s", $time, what);
  err_cnt++;
endtask

// One line per finished test
task automatic end_test(input string name, input int errs_before);
  tests_run++;
  if (err_cnt == errs_before) begin
    $display("%0t ns  %s: ok", $time, name);
  end else begin
    tests_bad++;
    $display("%0t ns  %s: %0d errors", $time, name, err_cnt - errs_before);
  end
endtask

// Drive one request and hold it until the MPU accepts it
task automatic send_req(input logic [31:0] addr, input logic we, input logic mis,
                        input logic dbg, output logic err_flag);
  int   wait_cyc;
  logic accepted;
  @(negedge clk);
  core_valid_i      = 1'b1;
  core_addr_i       = addr;
  core_we_i         = we;
  core_wdata_i      = ~addr;
  core_misaligned_i = mis;
  core_dbg_i        = dbg;
  accepted = 1'b0;
  err_flag = 1'b0;
  wait_cyc = 0;
  while (!accepted && wait_cyc < 20) begin
    @(posedge clk);
    wait_cyc++;
    accepted = core_ready_o;
    err_flag = core_mpu_err_o;
  end
  if (!accepted) begin
    report_issue($sformatf("request to %h was never accepted", addr));
  end
  @(negedge clk);
  core_valid_i      = 1'b0;
  core_misaligned_i = 1'b0;
  core_dbg_i        = 1'b0;
endtask

// Cycles are counted in rising edges after the accepting edge
task automatic wait_resp(input int max_cyc, output logic got, output int lat,
                         output logic [31:0] rdata, output mpu_status_e st);
  got   = 1'b0;
  lat   = 0;
  rdata = 32'h0;
  st    = MPU_OK;
  while (!got && lat < max_cyc) begin
    @(posedge clk);
    lat++;
    if (core_rvalid_o) begin
      got   = 1'b1;
      rdata = core_rdata_o;
      st    = core_status_o;
    end
  end
endtask

// Full access with response, error flag and bus log checks
task automatic access_check(input logic [31:0] addr, input logic we, input logic mis,
                            input logic dbg, input mpu_status_e exp_st);
  logic        err_flag;
  logic        exp_err;
  logic        got;
  int          lat;
  int          log_len;
  logic [31:0] rdata;
  logic [31:0] exp_data;
  mpu_status_e st;
  logic [2:0]  attr;
  exp_err  = (exp_st != MPU_OK);
  // Bus answers with address XOR pattern, faults carry zero
  exp_data = exp_err ? 32'h0 : (addr ^ 32'hA5A5_A5A5);
  log_len  = bus_log_addr.size();
  send_req(addr, we, mis, dbg, err_flag);
  if (err_flag != exp_err) report_mismatch("core_mpu_err_o", 32'(err_flag), 32'(exp_err));
  wait_resp(4, got, lat, rdata, st);
  if (!got) begin
    report_issue($sformatf("no response for the access to %h", addr));
  end else begin
    if (lat != 1) report_mismatch("response latency", lat, 1);
    if (st != exp_st) report_mismatch("core_status_o", 32'(st), 32'(exp_st));
    if ((!we || exp_err) && rdata != exp_data) report_mismatch("core_rdata_o", rdata, exp_data);
  end
  if (exp_err) begin
    if (bus_log_addr.size() != log_len) report_issue("faulted access reached the bus");
  end else if (bus_log_addr.size() != log_len + 1) begin
    report_issue($sformatf("access to %h did not reach the bus once", addr));
  end else begin
    attr = bus_log_attr[$];
    if (bus_log_addr[$] != addr) report_mismatch("bus_addr_o", bus_log_addr[$], addr);
    if (attr[2] != we) report_mismatch("bus_we_o", 32'(attr[2]), 32'(we));
    // Write data goes out exactly as the core drove it
    if (bus_log_wdata[$] != ~addr) report_mismatch("bus_wdata_o", bus_log_wdata[$], ~addr);
  end
endtask

task automatic check_attrs(input logic exp_buf, input logic exp_cach);
  logic [2:0] attr;
  attr = bus_log_attr[$];
  if (attr[1] != exp_buf) report_mismatch("bus_bufferable_o", 32'(attr[1]), 32'(exp_buf));
  if (attr[0] != exp_cach) report_mismatch("bus_cacheable_o", 32'(attr[0]), 32'(exp_cach));
endtask

//////////////////////////////
// Tests
//////////////////////////////

task automatic pass_through_and_stall();
  int          errs_before;
  int          log_len;
  int          lat;
  logic        got;
  logic [31:0] addr;
  logic [31:0] rdata;
  mpu_status_e st;
  errs_before = err_cnt;
  @(negedge clk);
  pmpcfg_i   = '0;
  priv_lvl_i = PRIV_LVL_M;
  // Word addresses inside main RAM
  for (int i = 0; i < 10; i++) begin
    addr = $random(seed) & 32'h0000_FFFC;
    access_check(addr, 1'b1, 1'b0, 1'b0, MPU_OK);
    check_attrs(1'b1, 1'b1);
    access_check(addr, 1'b0, 1'b0, 1'b0, MPU_OK);
    check_attrs(1'b1, 1'b1);
  end
  // Back-pressure, the bus holds ready low
  @(negedge clk);
  bus_ready_i  = 1'b0;
  core_valid_i = 1'b1;
  core_addr_i  = 32'h0000_0040;
  core_we_i    = 1'b0;
  log_len      = bus_log_addr.size();
  repeat (4) begin
    @(posedge clk);
    if (core_ready_o) report_mismatch("core_ready_o", 32'd1, 32'd0);
  end
  @(negedge clk);
  bus_ready_i = 1'b1;
  @(posedge clk);
  if (!core_ready_o) report_mismatch("core_ready_o", 32'd0, 32'd1);
  @(negedge clk);
  core_valid_i = 1'b0;
  if (bus_log_addr.size() != log_len + 1) report_issue("stalled read did not reach the bus once");
  wait_resp(4, got, lat, rdata, st);
  if (!got) begin
    report_issue("no response for the stalled read");
  end else begin
    if (rdata != (32'h0000_0040 ^ 32'hA5A5_A5A5)) begin
      report_mismatch("core_rdata_o", rdata, 32'h0000_0040 ^ 32'hA5A5_A5A5);
    end
    if (st != MPU_OK) report_mismatch("core_status_o", 32'(st), 32'(MPU_OK));
  end
  end_test("pass_through_and_stall", errs_before);
endtask

task automatic pmp_user_mode();
  int errs_before;
  errs_before = err_cnt;
  @(negedge clk);
  // Entry 0 TOR below 0x8000, read only
  pmpcfg_i   = 32'h0000_0009;
  pmpaddr_i  = {96'h0, 32'h0000_2000};
  priv_lvl_i = PRIV_LVL_U;
  access_check(32'h0000_1000, 1'b0, 1'b0, 1'b0, MPU_OK);
  access_check(32'h0000_1000, 1'b1, 1'b0, 1'b0, MPU_WR_FAULT);
  // No entry matches, user is denied
  access_check(32'h0000_9000, 1'b0, 1'b0, 1'b0, MPU_RE_FAULT);
  end_test("pmp_user_mode", errs_before);
endtask

task automatic pmp_lock_napot();
  int errs_before;
  errs_before = err_cnt;
  @(negedge clk);
  // Entry 1 locked NAPOT, 256 bytes at 0x4000, read only
  pmpcfg_i   = 32'h0000_9900;
  pmpaddr_i  = {64'h0, 32'h0000_101F, 32'h0};
  priv_lvl_i = PRIV_LVL_M;
  access_check(32'h0000_4010, 1'b1, 1'b0, 1'b0, MPU_WR_FAULT);
  access_check(32'h0000_40FC, 1'b0, 1'b0, 1'b0, MPU_OK);
  access_check(32'h0000_4100, 1'b1, 1'b0, 1'b0, MPU_OK);
  end_test("pmp_lock_napot", errs_before);
endtask

task automatic pma_rules();
  int errs_before;
  errs_before = err_cnt;
  @(negedge clk);
  pmpcfg_i  = '0;
  pmpaddr_i = '0;
  access_check(32'h1000_0002, 1'b0, 1'b1, 1'b0, MPU_RE_FAULT);
  access_check(32'h2000_0100, 1'b1, 1'b0, 1'b0, MPU_WR_FAULT);
  access_check(32'h2000_0100, 1'b0, 1'b0, 1'b0, MPU_OK);
  check_attrs(1'b0, 1'b1);
  // Debugger in the DM window, user mode would fail PMP otherwise
  @(negedge clk);
  priv_lvl_i = PRIV_LVL_U;
  access_check(32'hF000_0010, 1'b0, 1'b0, 1'b1, MPU_OK);
  check_attrs(1'b0, 1'b0);
  @(negedge clk);
  priv_lvl_i = PRIV_LVL_M;
  end_test("pma_rules", errs_before);
endtask

task automatic fault_waits_for_drain();
  int          errs_before;
  int          log_len;
  int          lat;
  logic        got;
  logic        err_flag;
  logic [31:0] rdata;
  mpu_status_e st;
  errs_before = err_cnt;
  @(negedge clk);
  core_one_txn_pend_n_i = 1'b0;
  log_len = bus_log_addr.size();
  send_req(32'h2000_0200, 1'b1, 1'b0, 1'b0, err_flag);
  if (!err_flag) report_mismatch("core_mpu_err_o", 32'd0, 32'd1);
  repeat (5) begin
    @(posedge clk);
    if (core_ready_o) report_mismatch("core_ready_o", 32'd1, 32'd0);
    if (core_rvalid_o) report_issue("fault response while older transactions pend");
  end
  @(negedge clk);
  core_one_txn_pend_n_i = 1'b1;
  // First edge closes the cycle with pend high, response at the next
  wait_resp(4, got, lat, rdata, st);
  if (!got) report_issue("no fault response after the core drained");
  else begin
    if (lat != 2) report_mismatch("response latency", lat, 2);
    if (st != MPU_WR_FAULT) report_mismatch("core_status_o", 32'(st), 32'(MPU_WR_FAULT));
  end
  if (bus_log_addr.size() != log_len) report_issue("faulted write reached the bus");
  end_test("fault_waits_for_drain", errs_before);
endtask

task automatic fault_without_wait();
  int          errs_before;
  int          log_len;
  int          lat;
  logic        got;
  logic        err_flag;
  logic [31:0] rdata;
  mpu_status_e st;
  errs_before = err_cnt;
  @(negedge clk);
  core_mpu_err_wait_i = 1'b0;
  log_len = bus_log_addr.size();
  send_req(32'h2000_0300, 1'b1, 1'b0, 1'b0, err_flag);
  if (!err_flag) report_mismatch("core_mpu_err_o", 32'd0, 32'd1);
  wait_resp(4, got, lat, rdata, st);
  if (got) report_issue("fault response although error wait is off");
  if (bus_log_addr.size() != log_len) report_issue("faulted write reached the bus");
  access_check(32'h0000_0300, 1'b0, 1'b0, 1'b0, MPU_OK);
  @(negedge clk);
  core_mpu_err_wait_i = 1'b1;
  end_test("fault_without_wait", errs_before);
endtask

/* test/tb_data_mpu.sv */
//////////////////////////////
// Testbench for the data-side MPU
// Clock, reset, bus responder with a transfer log,
// cycle limit and the closing summary
// Directed tests come from the included task file
//////////////////////////////

module tb_data_mpu import mpu_pkg::*, prot_cfg_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // Reset plus roughly 300 cycles of tests, wide margin on top
  localparam int MAX_CYCLES = 2000;

  logic                        clk;
  logic                        rst_n;
  logic                        core_valid_i;
  logic                        core_ready_o;
  logic [31:0]                 core_addr_i;
  logic                        core_we_i;
  logic [31:0]                 core_wdata_i;
  logic                        core_dbg_i;
  logic                        core_misaligned_i;
  logic                        core_one_txn_pend_n_i;
  logic                        core_mpu_err_wait_i;
  logic                        core_rvalid_o;
  logic [31:0]                 core_rdata_o;
  mpu_status_e                 core_status_o;
  logic                        core_mpu_err_o;
  logic [PMP_CFG_W_TOTAL-1:0]  pmpcfg_i;
  logic [PMP_ADDR_W_TOTAL-1:0] pmpaddr_i;
  privlvl_e                    priv_lvl_i;
  logic                        bus_valid_o;
  logic                        bus_ready_i;
  logic [31:0]                 bus_addr_o;
  logic                        bus_we_o;
  logic [31:0]                 bus_wdata_o;
  logic                        bus_bufferable_o;
  logic                        bus_cacheable_o;
  logic                        bus_rvalid_i;
  logic [31:0]                 bus_rdata_i;

  // Bus responder state and transfer log
  logic        resp_pend = 1'b0;
  logic [31:0] resp_data = 32'h0;
  logic [31:0] bus_log_addr [$];
  logic [31:0] bus_log_wdata [$];
  // Per transfer {we, bufferable, cacheable}
  logic [2:0]  bus_log_attr [$];

  int seed = 60;
  int err_cnt = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int cycle_cnt;

  data_mpu u_data_mpu (.*);

  `include "mpu_tests.svh"

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // Bus responder
  //////////////////////////////

  // Log each transfer, answer it one cycle later
  always @(posedge clk) begin
    if (bus_valid_o && bus_ready_i) begin
      bus_log_addr.push_back(bus_addr_o);
      bus_log_wdata.push_back(bus_wdata_o);
      bus_log_attr.push_back({bus_we_o, bus_bufferable_o, bus_cacheable_o});
    end
    resp_pend <= bus_valid_o && bus_ready_i;
    resp_data <= bus_addr_o ^ 32'hA5A5_A5A5;
  end

  always @(negedge clk) begin
    bus_rvalid_i <= resp_pend;
    bus_rdata_i  <= resp_pend ? resp_data : 32'h0;
  end

  // Cycle limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: no result after %0d clock cycles", MAX_CYCLES);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    rst_n                 = 1'b0;
    core_valid_i          = 1'b0;
    core_addr_i           = 32'h0;
    core_we_i             = 1'b0;
    core_wdata_i          = 32'h0;
    core_dbg_i            = 1'b0;
    core_misaligned_i     = 1'b0;
    core_one_txn_pend_n_i = 1'b1;
    core_mpu_err_wait_i   = 1'b1;
    pmpcfg_i              = '0;
    pmpaddr_i             = '0;
    priv_lvl_i            = PRIV_LVL_M;
    bus_ready_i           = 1'b1;
    bus_rvalid_i          = 1'b0;
    bus_rdata_i           = 32'h0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    pass_through_and_stall();
    pmp_user_mode();
    pmp_lock_napot();
    pma_rules();
    fault_waits_for_drain();
    fault_without_wait();

    $display("Summary: %0d tests, %0d with errors, %0d checks failed",
             tests_run, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+test
hdl/mpu_pkg.sv
hdl/prot_cfg_pkg.sv
hdl/pma_check.sv
hdl/pmp_check.sv
hdl/mpu_resp_ctrl.sv
hdl/data_mpu.sv
test/tb_data_mpu.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
# Exit status is 0 only if the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_data_mpu \
  -f files.f -o tb_data_mpu || exit 1
out=$(./obj_dir/tb_data_mpu)
echo "$out"
echo "$out" | grep -qx "Test completed successfully" && exit 0 || exit 1
